/* spi_regs.f */
spi_regs_pkg.sv
spi_slave.sv
spi_cmd_decoder.sv
spi_reg_bank.sv
spi_regs_top.sv
tb_clk_gen.sv
spi_regs_chk.sv
tb_spi_regs.sv

/* Bender.yml */
package:
  name: spi_regs

sources:
  - spi_regs_pkg.sv
  - spi_slave.sv
  - spi_cmd_decoder.sv
  - spi_reg_bank.sv
  - spi_regs_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - spi_regs_chk.sv
      - tb_spi_regs.sv

/* tb_spi_regs.sv */
// directed testbench for the spi register bank, mode 3 master model
// compare tasks, scoreboard of written registers, five tests
`default_nettype none

module tb_spi_regs
	import spi_regs_pkg::*;
();

	localparam int HALF_CYC    = 8;	// sclk half period in sys_clk cycles
	localparam int GAP_CYC     = 8;	// idle cycles after each byte
	localparam int RST_CYC     = 10;
	localparam int STROBE_WAIT = 2 * HALF_CYC;	// rx_valid timeout

	wire            sys_clk;
	logic           sys_rst_n;
	logic           cs;
	logic           sclk;
	logic           mosi;
	wire            miso;
	spi_byte_t      status_in;
	wire spi_byte_t ctrl_out;

	spi_byte_t tx_buf [18];	// command plus up to 17 data bytes
	spi_byte_t rx_buf [18];	// what came back on miso
	spi_byte_t model [16];	// expected register contents

	tb_clk_gen #(.PERIOD(4)) tb_clk_gen_inst (.clk(sys_clk));

	spi_regs_top spi_regs_top_inst (	// default mode 3
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.cs        (cs),
		.sclk      (sclk),
		.mosi      (mosi),
		.miso      (miso),
		.status_in (status_in),
		.ctrl_out  (ctrl_out)
	);

	task automatic abort_run();
		$display("*** TEST FAILED ***");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_byte(input string sig, input spi_byte_t expected,
			input spi_byte_t actual);
		if (actual !== expected) begin
			$display("ERR %0t %s expected %02h actual %02h", $time, sig, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_ctrl(input spi_byte_t expected);
		if (ctrl_out !== expected) begin
			$display("ERR %0t ctrl_out expected %02h actual %02h", $time, expected, ctrl_out);
			abort_run();
		end
	endtask

	// status location reads the live input and the rest the model
	function automatic spi_byte_t expected_read(input reg_addr_t a);
		if (a == STATUS_ADDR)
			return status_in;
		return model[a];
	endfunction

	function automatic spi_byte_t cmd_byte(input bit write, input reg_addr_t a);
		spi_byte_t c;
		c = '0;
		c[CMD_WRITE_BIT] = write;
		c[3:0] = a;	// start address
		return c;
	endfunction

	task automatic wait_rx_strobe();
		int  n;
		bit  seen;
		n = 0;
		seen = 1'b0;
		while (!seen && n < STROBE_WAIT) begin
			@(posedge sys_clk);
			seen = spi_regs_top_inst.rx_valid;
			n++;
		end
		if (!seen) begin
			$display("no byte strobe from the DUT within %0d cycles", STROBE_WAIT);
			abort_run();
		end
	endtask

	// mode 3 drives on falling sclk and samples miso on rising sclk
	task automatic shift_byte(input spi_byte_t tx, input int nbits, output spi_byte_t rx);
		int i;
		rx = '0;
		for (i = 7; i >= 8 - nbits; i--) begin
			sclk <= 1'b0;
			mosi <= tx[i];
			repeat (HALF_CYC) @(posedge sys_clk);
			rx[i] = miso;	// settled since the falling edge
			sclk <= 1'b1;
			if (i > 8 - nbits)
				repeat (HALF_CYC) @(posedge sys_clk);
		end
		if (nbits == 8)
			wait_rx_strobe();
		else
			repeat (HALF_CYC) @(posedge sys_clk);	// partial byte gives no strobe
		repeat (GAP_CYC) @(posedge sys_clk);
	endtask

	// one frame under cs with the last byte possibly cut short
	task automatic run_frame(input int nbytes, input int last_bits);
		int        b;
		spi_byte_t rx;
		cs <= 1'b0;
		repeat (HALF_CYC) @(posedge sys_clk);
		for (b = 0; b < nbytes; b++) begin
			shift_byte(tx_buf[b], (b == nbytes - 1) ? last_bits : 8, rx);
			rx_buf[b] = rx;
		end
		cs <= 1'b1;
		repeat (GAP_CYC) @(posedge sys_clk);
	endtask

	task automatic write_regs(input reg_addr_t start, input int n);	// data in tx_buf[1..n]
		reg_addr_t a;
		int        k;
		tx_buf[0] = cmd_byte(1'b1, start);
		run_frame(n + 1, 8);
		a = start;
		for (k = 1; k <= n; k++) begin
			if (a != STATUS_ADDR)
				model[a] = tx_buf[k];	// status writes dropped
			a = a + 4'd1;	// wraps like the decoder
		end
	endtask

	task automatic read_regs(input reg_addr_t start, input int n);	// data in rx_buf[1..n]
		int k;
		tx_buf[0] = cmd_byte(1'b0, start);
		for (k = 1; k <= n; k++)
			tx_buf[k] = '0;
		run_frame(n + 1, 8);
	endtask

	task automatic check_read_burst(input reg_addr_t start, input int n);
		reg_addr_t a;
		int        k;
		a = start;
		for (k = 1; k <= n; k++) begin
			check_byte($sformatf("rd_data[%0d]", a), expected_read(a), rx_buf[k]);
			a = a + 4'd1;
		end
	endtask

	task automatic test_reset_values();
		read_regs(4'd0, 16);	// whole bank with status at the end
		check_read_burst(4'd0, 16);
		check_ctrl(8'h00);
	endtask

	task automatic test_single_rw();
		reg_addr_t a;
		a = reg_addr_t'(1 + $urandom % 14);
		tx_buf[1] = spi_byte_t'($urandom);
		write_regs(a, 1);
		read_regs(a, 1);
		check_read_burst(a, 1);
	endtask

	task automatic test_wrap_burst();
		spi_byte_t wdat [4];
		int        k;
		for (k = 0; k < 4; k++) begin
			wdat[k] = spi_byte_t'($urandom);
			tx_buf[k + 1] = wdat[k];
		end
		write_regs(4'd14, 4);	// 14 15 0 1
		read_regs(4'd14, 4);
		check_byte("rd_data[14]", wdat[0], rx_buf[1]);
		check_byte("rd_data[15]", status_in, rx_buf[2]);
		check_byte("rd_data[0]", wdat[2], rx_buf[3]);
		check_byte("rd_data[1]", wdat[3], rx_buf[4]);
		check_ctrl(wdat[2]);
	endtask

	task automatic test_cs_abort();
		reg_addr_t t;
		reg_addr_t u;
		t = reg_addr_t'(1 + $urandom % 14);
		u = (t % 4'd14) + 4'd1;	// other writable address
		tx_buf[1] = 8'h5a;
		write_regs(t, 1);
		tx_buf[0] = cmd_byte(1'b1, t);
		tx_buf[1] = 8'ha5;
		run_frame(2, 5);	// cs up after five data bits
		tx_buf[1] = 8'h3c;
		write_regs(u, 1);	// command must not land in t
		read_regs(t, 1);
		check_read_burst(t, 1);
		read_regs(u, 1);
		check_read_burst(u, 1);
	endtask

	task automatic test_random_scoreboard();
		int k;
		status_in <= spi_byte_t'($urandom);
		for (k = 0; k < 15; k++) begin
			tx_buf[1] = spi_byte_t'($urandom);
			write_regs(reg_addr_t'(k), 1);
		end
		for (k = 0; k < 6; k++) begin	// overwrites that may hit status
			tx_buf[1] = spi_byte_t'($urandom);
			write_regs(reg_addr_t'($urandom), 1);
		end
		read_regs(4'd0, 16);
		check_read_burst(4'd0, 16);
		check_ctrl(model[0]);
	endtask

	initial begin
		int unsigned seed_ret;
		int          k;
		cs        = 1'b1;	// deselected
		sclk      = 1'b1;	// mode 3 idle level
		mosi      = 1'b0;
		sys_rst_n = 1'b0;
		status_in = 8'hc3;
		seed_ret  = $urandom(32'hdf8c71eb);
		for (k = 0; k < 16; k++)
			model[k] = '0;	// bank clears on reset
		repeat (RST_CYC) @(posedge sys_clk);
		sys_rst_n <= 1'b1;
		repeat (4) @(posedge sys_clk);
		test_reset_values();
		test_single_rw();
		test_wrap_burst();
		test_cs_abort();
		test_random_scoreboard();
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* spi_regs_chk.sv */
// bound checker on the top-level strobes and the bank write bus
// strobe width, write ordering, status location never written
`default_nettype none

module spi_regs_chk
	import spi_regs_pkg::*;
(
	input wire            sys_clk,
	input wire            sys_rst_n,
	input wire            rx_valid,	// slave byte strobe
	input wire            wr_en,	// bank write strobe
	input wire reg_addr_t wr_addr
);

	// one cycle strobe per byte
	a_rx_single: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_valid |=> !rx_valid)
		else $error("rx_valid high for two cycles");

	// write strobe only right after a byte strobe
	a_wr_after_rx: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		wr_en |-> $past(rx_valid))
		else $error("wr_en without rx_valid in the cycle before");

	// read-only location
	a_no_status_wr: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!(wr_en && (wr_addr == STATUS_ADDR)))
		else $error("write strobe at the status address");

endmodule

bind spi_regs_top spi_regs_chk spi_regs_chk_inst (
	.sys_clk   (sys_clk),
	.sys_rst_n (sys_rst_n),
	.rx_valid  (rx_valid),
	.wr_en     (wr_en),
	.wr_addr   (wr_addr)
);

`default_nettype wire

/* tb_clk_gen.sv */
// testbench clock source
// free-running clock, period set by parameter
`default_nettype none

module tb_clk_gen #(
	parameter int PERIOD = 4	// clock period in time units
) (
	output logic clk
);

	initial clk = 1'b0;	// start low, first rise at PERIOD/2

	always #(PERIOD / 2) clk = ~clk;

endmodule

`default_nettype wire

/* spi_regs_top.sv */
// top level of the spi register bank
// spi slave, command decoder and register bank
// CPOL and CPHA passed down to the slave
`default_nettype none

module spi_regs_top
	import spi_regs_pkg::*;
#(
	parameter bit CPOL = 1'b1,	// sclk idle level
	parameter bit CPHA = 1'b1	// sample edge select
) (
	input  wire            sys_clk,	// system clock
	input  wire            sys_rst_n,	// sync reset, active low
	input  wire            cs,	// spi chip select, active low
	input  wire            sclk,	// spi clock
	input  wire            mosi,	// master out
	output wire            miso,	// slave out
	input  wire spi_byte_t status_in,	// status at address 15
	output wire spi_byte_t ctrl_out	// register 0
);

	// slave to decoder
	wire            rx_valid;
	wire spi_byte_t rx_byte;
	wire            frame_start;
	wire spi_byte_t tx_byte;
	// decoder to bank
	wire            wr_en;
	wire reg_addr_t wr_addr;
	wire spi_byte_t wr_data;
	wire reg_addr_t rd_addr;
	wire spi_byte_t rd_data;

	spi_slave #(
		.CPOL (CPOL),
		.CPHA (CPHA)
	) spi_slave_inst (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.cs          (cs),
		.sclk        (sclk),
		.mosi        (mosi),
		.miso        (miso),
		.tx_byte     (tx_byte),
		.rx_valid    (rx_valid),
		.rx_byte     (rx_byte),
		.frame_start (frame_start)
	);

	spi_cmd_decoder spi_cmd_decoder_inst (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.frame_start (frame_start),
		.rx_valid    (rx_valid),
		.rx_byte     (rx_byte),
		.rd_data     (rd_data),
		.tx_byte     (tx_byte),
		.wr_en       (wr_en),
		.wr_addr     (wr_addr),
		.wr_data     (wr_data),
		.rd_addr     (rd_addr)
	);

	spi_reg_bank spi_reg_bank_inst (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.rd_addr   (rd_addr),
		.status_in (status_in),
		.rd_data   (rd_data),
		.ctrl_out  (ctrl_out)
	);

endmodule

`default_nettype wire

/* spi_reg_bank.sv */
// sixteen-entry register bank
// fifteen writable bytes, read-only status at the top address
// register 0 drives the control output
`default_nettype none

module spi_reg_bank
	import spi_regs_pkg::*;
(
	input  wire            sys_clk,	// system clock
	input  wire            sys_rst_n,	// sync reset, active low
	input  wire            wr_en,	// write strobe
	input  wire reg_addr_t wr_addr,	// write address
	input  wire spi_byte_t wr_data,	// write data
	input  wire reg_addr_t rd_addr,	// read address
	input  wire spi_byte_t status_in,	// external status
	output spi_byte_t      rd_data,	// combinational read data
	output spi_byte_t      ctrl_out	// register 0
);

	localparam int NUM_RW = int'(STATUS_ADDR);	// writable entries 0..14

	spi_byte_t regs [NUM_RW];	// writable storage

	// writes, status address dropped
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			for (int i = 0; i < NUM_RW; i++)
				regs[i] <= '0;	// all clear
		end else if (wr_en && (wr_addr != STATUS_ADDR)) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// read mux
	always_comb begin
		if (rd_addr == STATUS_ADDR)
			rd_data = status_in;	// live status value
		else
			rd_data = regs[rd_addr];
	end

	assign ctrl_out = regs[0];	// control register

endmodule

`default_nettype wire

/* spi_cmd_decoder.sv */
// command decoder between the spi slave and the register bank
// parses the command byte, keeps the burst address
// issues write strobes and selects read data for the slave
`default_nettype none

module spi_cmd_decoder
	import spi_regs_pkg::*;
(
	input  wire            sys_clk,	// system clock
	input  wire            sys_rst_n,	// sync reset, active low
	input  wire            frame_start,	// new frame, next byte is a command
	input  wire            rx_valid,	// byte strobe from slave
	input  wire spi_byte_t rx_byte,	// byte from slave
	input  wire spi_byte_t rd_data,	// bank read data
	output spi_byte_t      tx_byte,	// byte to slave
	output logic           wr_en,	// bank write strobe
	output reg_addr_t      wr_addr,	// bank write address
	output spi_byte_t      wr_data,	// bank write data
	output reg_addr_t      rd_addr	// bank read address
);

	dec_state_t dec_state;	// what the next byte means
	reg_addr_t  addr;	// current burst address
	logic       data_byte;	// data byte of a write burst
	logic       wr_ok;	// write allowed at current address

	assign data_byte = rx_valid && (dec_state == D_WR_DATA);
	assign wr_ok     = (addr != STATUS_ADDR);	// status location never written

	// fsm and burst address
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			dec_state <= D_CMD;
			addr      <= '0;
		end else if (frame_start) begin
			dec_state <= D_CMD;	// every frame opens with a command
		end else if (rx_valid) begin
			case (dec_state)
				D_CMD: begin
					addr <= reg_addr_t'(rx_byte[3:0]);	// start address
					if (rx_byte[CMD_WRITE_BIT])
						dec_state <= D_WR_DATA;
					else
						dec_state <= D_RD_DATA;
				end
				D_WR_DATA, D_RD_DATA: begin
					addr <= addr + 4'd1;	// wraps 15 to 0
				end
				default: begin
					dec_state <= D_CMD;
				end
			endcase
		end
	end

	// write strobe, one cycle after rx_valid
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			wr_en <= 1'b0;
		else
			wr_en <= data_byte && wr_ok;
	end

	// write payload, captured with the strobe
	always_ff @(posedge sys_clk) begin
		if (rx_valid) begin
			wr_addr <= addr;
			wr_data <= rx_byte;
		end
	end

	// read path
	assign rd_addr = addr;	// combinational into bank
	// slave reloads in idle, one cycle after addr moves
	assign tx_byte = (dec_state == D_RD_DATA) ? rd_data : '0;

endmodule

`default_nettype wire

/* spi_slave.sv */
// spi slave for all four modes, chosen by CPOL and CPHA
// two-flop pin synchronizers and sclk edge detection in the sys_clk domain
// byte fsm with rx and tx shift registers, msb first
`default_nettype none

module spi_slave
	import spi_regs_pkg::*;
#(
	parameter bit CPOL = 1'b1,	// sclk idle level
	parameter bit CPHA = 1'b1	// 0 samples on leading edge
) (
	input  wire            sys_clk,	// system clock
	input  wire            sys_rst_n,	// sync reset, active low
	input  wire            cs,	// chip select from master, active low
	input  wire            sclk,	// spi clock, async to sys_clk
	input  wire            mosi,	// master out
	output logic           miso,	// slave out
	input  wire spi_byte_t tx_byte,	// next byte to send
	output logic           rx_valid,	// byte received strobe
	output spi_byte_t      rx_byte,	// received byte
	output logic           frame_start	// cs fall strobe
);

	// last edge index of a byte, mode 0 and 2 end on the 8th leading edge
	localparam logic [3:0] LAST_EDGE = CPHA ? 4'd15 : 4'd14;

	logic [1:0]   cs_sync;	// [1] is synchronized cs
	logic [1:0]   sclk_sync;	// [1] is synchronized sclk
	logic [1:0]   mosi_sync;	// [1] is synchronized mosi
	logic         cs_dly;	// synced cs one cycle late
	logic         sclk_dly;	// synced sclk one cycle late
	logic         sclk_rise;
	logic         sclk_fall;
	logic         lead_edge;	// first edge of each sclk cycle
	logic         trail_edge;	// second edge of each sclk cycle
	logic         edge_hit;	// the edge the fsm waits for
	logic         sample_now;	// capture mosi this cycle
	logic         shift_now;	// advance miso this cycle
	logic [3:0]   edge_cnt;	// sclk edges seen in this byte
	slave_state_t state;
	spi_byte_t    rx_shift;	// receive shift register
	spi_byte_t    tx_shift;	// transmit shift register

	// pin synchronizers, idle levels on reset
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			cs_sync   <= 2'b11;	// deselected
			cs_dly    <= 1'b1;
			sclk_sync <= {2{CPOL}};	// sclk at idle level
			sclk_dly  <= CPOL;
			mosi_sync <= 2'b00;
		end else begin
			cs_sync   <= {cs_sync[0], cs};
			cs_dly    <= cs_sync[1];
			sclk_sync <= {sclk_sync[0], sclk};
			sclk_dly  <= sclk_sync[1];
			mosi_sync <= {mosi_sync[0], mosi};
		end
	end

	assign sclk_rise   = sclk_sync[1] & ~sclk_dly;
	assign sclk_fall   = ~sclk_sync[1] & sclk_dly;
	assign lead_edge   = CPOL ? sclk_fall : sclk_rise;	// leaves idle level
	assign trail_edge  = CPOL ? sclk_rise : sclk_fall;	// back to idle level
	assign edge_hit    = edge_cnt[0] ? trail_edge : lead_edge;	// even count waits for leading
	assign frame_start = cs_dly & ~cs_sync[1];	// synced cs falling

	// sample on even edges for cpha 0, odd edges for cpha 1
	assign sample_now = (state == S_EDGE) && (edge_cnt[0] == CPHA);
	// shift on the other edges, except the very first one
	assign shift_now  = (state == S_EDGE) && (edge_cnt[0] != CPHA) && (edge_cnt != 4'd0);

	// byte fsm
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			state <= S_IDLE;
		end else if (cs_sync[1] || frame_start) begin
			state <= S_IDLE;	// abort, partial byte dropped
			// extra idle cycle at cs fall lets the decoder settle tx_byte
		end else begin
			case (state)
				S_IDLE: begin
					state <= S_WAIT_EDGE;
				end
				S_WAIT_EDGE: begin
					if (edge_hit)
						state <= S_EDGE;
				end
				S_EDGE: begin
					if (edge_cnt == LAST_EDGE)
						state <= S_LAST_HALF;	// all 8 bits in
					else
						state <= S_WAIT_EDGE;
				end
				S_LAST_HALF: begin
					state <= S_STROBE;
				end
				S_STROBE: begin
					state <= S_FINISH;
				end
				S_FINISH: begin
					state <= S_IDLE;	// reload tx for next byte
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	// edge counter
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			edge_cnt <= 4'd0;
		else if (state == S_IDLE)
			edge_cnt <= 4'd0;	// fresh byte
		else if (state == S_EDGE)
			edge_cnt <= edge_cnt + 4'd1;
	end

	// tx shift, msb already on miso before the first edge
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			tx_shift <= '0;	// miso low after reset
		else if (state == S_IDLE)
			tx_shift <= tx_byte;
		else if (shift_now)
			tx_shift <= {tx_shift[6:0], 1'b0};
	end

	// rx shift
	always_ff @(posedge sys_clk) begin
		if (sample_now)
			rx_shift <= {rx_shift[6:0], mosi_sync[1]};
	end

	assign miso     = tx_shift[7];	// msb first
	assign rx_byte  = rx_shift;	// stable through the strobe
	assign rx_valid = (state == S_STROBE);

endmodule

`default_nettype wire

/* spi_regs_pkg.sv */
// shared types for the spi register bank
// byte and address vectors, fsm state enums, command field constants
`default_nettype none

package spi_regs_pkg;

	typedef logic [7:0] spi_byte_t;	// one spi byte or register value
	typedef logic [3:0] reg_addr_t;	// register bank address

	// slave byte fsm, one pass per spi byte
	typedef enum logic [2:0] {
		S_IDLE      = 3'd0,	// load tx byte, clear edge count
		S_WAIT_EDGE = 3'd1,	// wait for next expected sclk edge
		S_EDGE      = 3'd2,	// act on one sclk edge
		S_LAST_HALF = 3'd3,	// byte complete
		S_STROBE    = 3'd4,	// rx_valid high here
		S_FINISH    = 3'd5	// one spare cycle before reload
	} slave_state_t;

	// decoder fsm
	typedef enum logic [1:0] {
		D_CMD     = 2'd0,	// next byte is a command
		D_WR_DATA = 2'd1,	// write burst
		D_RD_DATA = 2'd2	// read burst
	} dec_state_t;

	localparam int        CMD_WRITE_BIT = 7;	// set means write
	localparam reg_addr_t STATUS_ADDR   = 4'd15;	// read-only status location

endpackage

`default_nettype wire
